//--- rtl/id_pkg.sv
package id_pkg;

    localparam int DATA_W         = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int NUM_REGS       = 32;
    localparam int NUM_FWD_STAGES = 3;   // 0 = execute, 1 = memory, 2 = write-back

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rs,
        src1_shamt,
        src1_pc
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_rt,
        src2_simm,
        src2_uimm,
        src2_eight    // link address is pc + 8
    } src2_sel_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_bgez,
        br_bgtz,
        br_blez,
        br_bltz,
        br_j,         // j and jal
        br_jr
    } br_kind_e;

    typedef struct packed {
        logic [DATA_W-1:0] inst;
        logic [DATA_W-1:0] pc;
    } fetch_bus_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } wb_bus_t;

    // one later stage, as seen by the hazard check
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] dest;
        logic                  fwd_valid;   // result already known in that stage
        logic [DATA_W-1:0]     fwd_data;
    } stage_dest_t;

    typedef struct packed {
        alu_op_e               alu_op;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        mem_op_e               mem_op;
        br_kind_e              br_kind;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic                  use_rs;
        logic                  use_rt;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [4:0]            shamt;
        logic [15:0]           imm;
        logic [25:0]           jidx;
    } decode_ctrl_t;

    typedef struct packed {
        alu_op_e               alu_op;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        mem_op_e               mem_op;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [4:0]            shamt;
        logic [15:0]           imm;
        logic [DATA_W-1:0]     rs_value;
        logic [DATA_W-1:0]     rt_value;
        logic [DATA_W-1:0]     pc;
    } exec_bus_t;

    typedef struct packed {
        logic              taken;
        logic [DATA_W-1:0] target;
    } br_bus_t;

endpackage

//--- rtl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [id_pkg::DATA_W-1:0] inst,
    output id_pkg::decode_ctrl_t      ctrl
);
    import id_pkg::*;

    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] func;
    logic       known;
    logic       zero_ok;   // reserved fields hold zero

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];

    always_comb begin
        known         = 1'b0;
        zero_ok       = 1'b1;
        ctrl.alu_op   = alu_add;
        ctrl.src1_sel = src1_rs;
        ctrl.src2_sel = src2_rt;
        ctrl.mem_op   = mem_none;
        ctrl.br_kind  = br_none;
        ctrl.gr_we    = 1'b0;
        ctrl.dest     = rd;
        ctrl.use_rs   = 1'b0;
        ctrl.use_rt   = 1'b0;
        ctrl.rs       = rs;
        ctrl.rt       = rt;
        ctrl.shamt    = sa;
        ctrl.imm      = inst[15:0];
        ctrl.jidx     = inst[25:0];

        case (op)
            6'h00: begin   // special
                known       = 1'b1;
                ctrl.gr_we  = 1'b1;
                ctrl.use_rs = 1'b1;
                ctrl.use_rt = 1'b1;
                zero_ok     = (sa == '0);
                case (func)
                    6'h20, 6'h21: ctrl.alu_op = alu_add;
                    6'h22, 6'h23: ctrl.alu_op = alu_sub;
                    6'h2a: ctrl.alu_op = alu_slt;
                    6'h2b: ctrl.alu_op = alu_sltu;
                    6'h24: ctrl.alu_op = alu_and;
                    6'h25: ctrl.alu_op = alu_or;
                    6'h26: ctrl.alu_op = alu_xor;
                    6'h27: ctrl.alu_op = alu_nor;
                    6'h04: ctrl.alu_op = alu_sll;
                    6'h06: ctrl.alu_op = alu_srl;
                    6'h07: ctrl.alu_op = alu_sra;
                    6'h00, 6'h02, 6'h03: begin   // shift by shamt
                        ctrl.alu_op   = func[1] ? (func[0] ? alu_sra : alu_srl) : alu_sll;
                        ctrl.src1_sel = src1_shamt;
                        ctrl.use_rs   = 1'b0;
                        zero_ok       = (rs == '0);
                    end
                    6'h08: begin   // jr
                        ctrl.br_kind = br_jr;
                        ctrl.gr_we   = 1'b0;
                        ctrl.use_rt  = 1'b0;
                        zero_ok      = (rt == '0) && (rd == '0) && (sa == '0);
                    end
                    default: known = 1'b0;
                endcase
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e: begin
                known         = 1'b1;
                ctrl.gr_we    = 1'b1;
                ctrl.use_rs   = 1'b1;
                ctrl.dest     = rt;
                ctrl.src2_sel = op[2] ? src2_uimm : src2_simm;   // logic ops zero-extend
                case (op[2:0])
                    3'b010:  ctrl.alu_op = alu_slt;
                    3'b011:  ctrl.alu_op = alu_sltu;
                    3'b100:  ctrl.alu_op = alu_and;
                    3'b101:  ctrl.alu_op = alu_or;
                    3'b110:  ctrl.alu_op = alu_xor;
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            6'h0f: begin   // lui
                known         = 1'b1;
                zero_ok       = (rs == '0);
                ctrl.alu_op   = alu_lui;
                ctrl.src2_sel = src2_simm;
                ctrl.gr_we    = 1'b1;
                ctrl.dest     = rt;
            end
            6'h23, 6'h2b: begin   // lw, sw
                known         = 1'b1;
                ctrl.src2_sel = src2_simm;
                ctrl.use_rs   = 1'b1;
                ctrl.mem_op   = op[3] ? mem_store : mem_load;
                ctrl.use_rt   = op[3];     // store data
                ctrl.gr_we    = !op[3];
                ctrl.dest     = rt;
            end
            6'h04, 6'h05: begin
                known        = 1'b1;
                ctrl.use_rs  = 1'b1;
                ctrl.use_rt  = 1'b1;
                ctrl.br_kind = op[0] ? br_bne : br_beq;
            end
            6'h01: begin   // regimm, only bltz and bgez
                known        = 1'b1;
                zero_ok      = (rt[4:1] == '0);
                ctrl.use_rs  = 1'b1;
                ctrl.br_kind = rt[0] ? br_bgez : br_bltz;
            end
            6'h06, 6'h07: begin
                known        = 1'b1;
                zero_ok      = (rt == '0);
                ctrl.use_rs  = 1'b1;
                ctrl.br_kind = op[0] ? br_bgtz : br_blez;
            end
            6'h02: begin
                known        = 1'b1;
                ctrl.br_kind = br_j;
            end
            6'h03: begin   // jal writes pc + 8 to the link register
                known         = 1'b1;
                ctrl.br_kind  = br_j;
                ctrl.src1_sel = src1_pc;
                ctrl.src2_sel = src2_eight;
                ctrl.gr_we    = 1'b1;
                ctrl.dest     = LINK_REG;
            end
            default: known = 1'b0;
        endcase

        if (!known || !zero_ok) begin
            ctrl.alu_op   = alu_add;
            ctrl.src1_sel = src1_rs;
            ctrl.src2_sel = src2_rt;
            ctrl.mem_op   = mem_none;
            ctrl.br_kind  = br_none;
            ctrl.gr_we    = 1'b0;
            ctrl.use_rs   = 1'b0;
            ctrl.use_rt   = 1'b0;
        end
    end

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                          clk,
    input  logic [id_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [id_pkg::REG_ADDR_W-1:0] raddr2,
    input  id_pkg::wb_bus_t               wr,
    output logic [id_pkg::DATA_W-1:0]     rdata1,
    output logic [id_pkg::DATA_W-1:0]     rdata2
);
    import id_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // $0 is never written, so force it here
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  id_pkg::decode_ctrl_t                                ctrl,
    input  logic [id_pkg::DATA_W-1:0]                           rf_rdata1,
    input  logic [id_pkg::DATA_W-1:0]                           rf_rdata2,
    input  id_pkg::stage_dest_t [id_pkg::NUM_FWD_STAGES-1:0]    stage_dests,
    output logic [id_pkg::DATA_W-1:0]                           rs_value,
    output logic [id_pkg::DATA_W-1:0]                           rt_value,
    output logic                                                stall
);
    import id_pkg::*;

    // operand 0 is rs, operand 1 is rt
    logic [1:0][REG_ADDR_W-1:0] addr;
    logic [1:0]                 used;
    logic [1:0][DATA_W-1:0]     rf_val;
    logic [1:0][DATA_W-1:0]     value;
    logic [1:0]                 hit;
    logic [1:0]                 wait_fwd;

    assign addr[0]   = ctrl.rs;
    assign addr[1]   = ctrl.rt;
    assign used[0]   = ctrl.use_rs;
    assign used[1]   = ctrl.use_rt;
    assign rf_val[0] = rf_rdata1;
    assign rf_val[1] = rf_rdata2;

    // closest stage wins, execute first
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            value[i]    = rf_val[i];
            hit[i]      = 1'b0;
            wait_fwd[i] = 1'b0;
            for (int s = 0; s < NUM_FWD_STAGES; s++) begin
                if (!hit[i] && used[i] && addr[i] != '0 &&
                    stage_dests[s].we && stage_dests[s].dest == addr[i]) begin
                    hit[i] = 1'b1;
                    if (stage_dests[s].fwd_valid) begin
                        value[i] = stage_dests[s].fwd_data;
                    end else begin
                        wait_fwd[i] = 1'b1;   // result not produced yet
                    end
                end
            end
        end
    end

    assign rs_value = value[0];
    assign rt_value = value[1];
    assign stall    = |wait_fwd;

endmodule

//--- rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::decode_ctrl_t      ctrl,
    input  logic                      ds_valid,
    input  logic [id_pkg::DATA_W-1:0] pc,
    input  logic [id_pkg::DATA_W-1:0] rs_value,
    input  logic [id_pkg::DATA_W-1:0] rt_value,
    output id_pkg::br_bus_t           br
);
    import id_pkg::*;

    logic [DATA_W-1:0] pc_plus4;
    logic [DATA_W-1:0] br_offset;
    logic [DATA_W-1:0] target;
    logic              cond;
    logic              rs_neg;
    logic              rs_zero;

    assign pc_plus4  = pc + DATA_W'(4);
    assign br_offset = {{(DATA_W-18){ctrl.imm[15]}}, ctrl.imm, 2'b00};
    assign rs_neg    = rs_value[DATA_W-1];
    assign rs_zero   = (rs_value == '0);

    always_comb begin
        cond   = 1'b0;
        target = pc_plus4 + br_offset;
        case (ctrl.br_kind)
            br_beq:  cond = (rs_value == rt_value);
            br_bne:  cond = (rs_value != rt_value);
            br_bgez: cond = !rs_neg;
            br_bgtz: cond = !rs_neg && !rs_zero;
            br_blez: cond = rs_neg || rs_zero;
            br_bltz: cond = rs_neg;
            br_j: begin
                cond   = 1'b1;
                target = {pc_plus4[DATA_W-1 -: 4], ctrl.jidx, 2'b00};   // same 256MB region
            end
            br_jr: begin
                cond   = 1'b1;
                target = rs_value;
            end
            default: cond = 1'b0;
        endcase
    end

    assign br = '{taken: ds_valid && cond, target: target};

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             fs_to_ds_valid,
    input  id_pkg::fetch_bus_t                               fs_to_ds_bus,
    output logic                                             ds_allowin,
    input  logic                                             es_allowin,
    output logic                                             ds_to_es_valid,
    output id_pkg::exec_bus_t                                ds_to_es_bus,
    output id_pkg::br_bus_t                                  br_bus,
    input  id_pkg::wb_bus_t                                  ws_to_rf_bus,
    input  id_pkg::stage_dest_t [id_pkg::NUM_FWD_STAGES-1:0] stage_dests
);
    import id_pkg::*;

    logic              ds_valid;
    logic              ds_ready_go;
    fetch_bus_t        ds_bus_r;
    decode_ctrl_t      ctrl;
    logic [DATA_W-1:0] rf_rdata1;
    logic [DATA_W-1:0] rf_rdata2;
    logic [DATA_W-1:0] rs_value;
    logic [DATA_W-1:0] rt_value;
    logic              stall;

    assign ds_ready_go    = !stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_bus_r <= fs_to_ds_bus;
        end
    end

    inst_decoder decoder_i (
        .inst (ds_bus_r.inst),
        .ctrl (ctrl)
    );

    regfile regfile_i (
        .clk    (clk),
        .raddr1 (ctrl.rs),
        .raddr2 (ctrl.rt),
        .wr     (ws_to_rf_bus),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    hazard_unit hazard_i (
        .ctrl        (ctrl),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .stage_dests (stage_dests),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .stall       (stall)
    );

    branch_unit branch_i (
        .ctrl     (ctrl),
        .ds_valid (ds_valid),
        .pc       (ds_bus_r.pc),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .br       (br_bus)
    );

    always_comb begin
        ds_to_es_bus.alu_op   = ctrl.alu_op;
        ds_to_es_bus.src1_sel = ctrl.src1_sel;
        ds_to_es_bus.src2_sel = ctrl.src2_sel;
        ds_to_es_bus.mem_op   = ctrl.mem_op;
        ds_to_es_bus.gr_we    = ctrl.gr_we;
        ds_to_es_bus.dest     = ctrl.dest;
        ds_to_es_bus.shamt    = ctrl.shamt;
        ds_to_es_bus.imm      = ctrl.imm;
        ds_to_es_bus.rs_value = rs_value;
        ds_to_es_bus.rt_value = rt_value;   // also store data for sw
        ds_to_es_bus.pc       = ds_bus_r.pc;
    end

    // held output must not move while execute is blocked
    assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> ds_to_es_valid && $stable(ds_to_es_bus))
        else $error("decode output changed under back-pressure");

endmodule

//--- tests/id_ref.svh
`ifndef ID_REF_SVH
`define ID_REF_SVH

// expected control fields for the supported instruction words
function automatic decode_ctrl_t decode_word(input logic [31:0] inst);
    decode_ctrl_t c;
    logic [5:0]   op;
    op         = inst[31:26];
    c          = '0;
    c.alu_op   = alu_add;
    c.src1_sel = src1_rs;
    c.src2_sel = src2_rt;
    c.mem_op   = mem_none;
    c.br_kind  = br_none;
    c.dest     = inst[15:11];
    c.rs       = inst[25:21];
    c.rt       = inst[20:16];
    c.shamt    = inst[10:6];
    c.imm      = inst[15:0];
    c.jidx     = inst[25:0];
    case (op)
        6'h00: begin
            c.gr_we  = 1'b1;
            c.use_rs = 1'b1;
            c.use_rt = 1'b1;
            case (inst[5:0])
                6'h22, 6'h23: c.alu_op = alu_sub;
                6'h2a: c.alu_op = alu_slt;
                6'h2b: c.alu_op = alu_sltu;
                6'h24: c.alu_op = alu_and;
                6'h25: c.alu_op = alu_or;
                6'h26: c.alu_op = alu_xor;
                6'h27: c.alu_op = alu_nor;
                6'h00, 6'h04: c.alu_op = alu_sll;
                6'h02, 6'h06: c.alu_op = alu_srl;
                6'h03, 6'h07: c.alu_op = alu_sra;
                6'h08: begin
                    c.br_kind = br_jr;
                    c.gr_we   = 1'b0;
                    c.use_rt  = 1'b0;
                end
                default: c.alu_op = alu_add;
            endcase
            if (inst[5:2] == 4'b0000) begin   // constant shift amount
                c.src1_sel = src1_shamt;
                c.use_rs   = 1'b0;
            end
        end
        6'h0a: c.alu_op = alu_slt;
        6'h0b: c.alu_op = alu_sltu;
        6'h0c: c.alu_op = alu_and;
        6'h0d: c.alu_op = alu_or;
        6'h0e: c.alu_op = alu_xor;
        6'h0f: c.alu_op = alu_lui;
        6'h23: begin
            c.mem_op = mem_load;
            c.gr_we  = 1'b1;
        end
        6'h2b: begin
            c.mem_op = mem_store;
            c.use_rt = 1'b1;
        end
        6'h04: c.br_kind = br_beq;
        6'h05: c.br_kind = br_bne;
        6'h01: c.br_kind = inst[16] ? br_bgez : br_bltz;
        6'h06: c.br_kind = br_blez;
        6'h07: c.br_kind = br_bgtz;
        6'h02: c.br_kind = br_j;
        6'h03: begin
            c.br_kind  = br_j;
            c.src1_sel = src1_pc;
            c.src2_sel = src2_eight;   // link value pc + 8
            c.gr_we    = 1'b1;
            c.dest     = LINK_REG;
        end
        default: c.alu_op = alu_add;   // addi, addiu
    endcase
    if (op >= 6'h08 && op <= 6'h0f) begin
        c.gr_we    = 1'b1;
        c.dest     = inst[20:16];
        c.use_rs   = (op != 6'h0f);
        c.src2_sel = (op >= 6'h0c && op <= 6'h0e) ? src2_uimm : src2_simm;
    end
    if (c.mem_op != mem_none) begin
        c.src2_sel = src2_simm;
        c.use_rs   = 1'b1;
        c.dest     = inst[20:16];
    end
    if (op == 6'h01 || (op >= 6'h04 && op <= 6'h07)) begin
        c.use_rs = 1'b1;
    end
    if (op == 6'h04 || op == 6'h05) begin
        c.use_rt = 1'b1;
    end
    return c;
endfunction

// operand after forwarding, returns 1 when the instruction has to wait
function automatic logic resolve_operand(input logic [4:0] addr, input logic used,
                                         input logic [31:0] rf_val,
                                         input stage_dest_t [NUM_FWD_STAGES-1:0] sd,
                                         output logic [31:0] value);
    logic found;
    found           = 1'b0;
    value           = rf_val;
    resolve_operand = 1'b0;
    if (used && addr != 5'd0) begin
        for (int s = 0; s < NUM_FWD_STAGES; s++) begin
            if (!found && sd[s].we && sd[s].dest == addr) begin
                found = 1'b1;
                if (sd[s].fwd_valid) begin
                    value = sd[s].fwd_data;
                end else begin
                    resolve_operand = 1'b1;
                end
            end
        end
    end
endfunction

function automatic exec_bus_t pack_exec(input decode_ctrl_t c, input logic [31:0] rs_v,
                                        input logic [31:0] rt_v, input logic [31:0] pc);
    exec_bus_t e;
    e.alu_op   = c.alu_op;
    e.src1_sel = c.src1_sel;
    e.src2_sel = c.src2_sel;
    e.mem_op   = c.mem_op;
    e.gr_we    = c.gr_we;
    e.dest     = c.dest;
    e.shamt    = c.shamt;
    e.imm      = c.imm;
    e.rs_value = rs_v;
    e.rt_value = rt_v;
    e.pc       = pc;
    return e;
endfunction

function automatic br_bus_t branch_outcome(input decode_ctrl_t c, input logic [31:0] pc,
                                           input logic [31:0] rs_v, input logic [31:0] rt_v);
    br_bus_t     b;
    logic [31:0] seq_pc;
    seq_pc   = pc + 32'd4;
    b.taken  = 1'b0;
    b.target = seq_pc + {{14{c.imm[15]}}, c.imm, 2'b00};
    case (c.br_kind)
        br_beq:  b.taken = (rs_v == rt_v);
        br_bne:  b.taken = (rs_v != rt_v);
        br_bgez: b.taken = ($signed(rs_v) >= 0);
        br_bgtz: b.taken = ($signed(rs_v) > 0);
        br_blez: b.taken = ($signed(rs_v) <= 0);
        br_bltz: b.taken = ($signed(rs_v) < 0);
        br_j: begin
            b.taken  = 1'b1;
            b.target = {seq_pc[31:28], c.jidx, 2'b00};
        end
        br_jr: begin
            b.taken  = 1'b1;
            b.target = rs_v;
        end
        default: b.taken = 1'b0;
    endcase
    return b;
endfunction

`endif

//--- tests/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
    import id_pkg::*;

    `include "id_ref.svh"

    localparam int MAX_WAIT = 40;
    localparam int BP_COUNT = 24;

    logic                             clk;
    logic                             reset;
    logic                             fs_to_ds_valid;
    fetch_bus_t                       fs_to_ds_bus;
    logic                             ds_allowin;
    logic                             es_allowin;
    logic                             ds_to_es_valid;
    exec_bus_t                        ds_to_es_bus;
    br_bus_t                          br_bus;
    wb_bus_t                          ws_to_rf_bus;
    stage_dest_t [NUM_FWD_STAGES-1:0] stage_dests;

    integer            seed;
    string             test_name;
    int                err_exec;
    int                err_branch;
    int                err_flag;
    int                err_timeout;
    int                sent;
    int                received;
    logic [DATA_W-1:0] shadow [NUM_REGS];   // expected register file contents
    fetch_bus_t        held_q [$];          // instruction the stage should hold
    logic [5:0]        r_funcs [13];
    logic [31:0]       bp_insts [BP_COUNT];
    logic              bp_done;

    id_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_exec(input string what, input exec_bus_t exp, input exec_bus_t act);
        if (act !== exp) begin
            err_exec++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_branch(input string what, input br_bus_t exp, input br_bus_t act);
        if (act !== exp) begin
            err_branch++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            err_flag++;
            $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin : compare
        decode_ctrl_t c;
        logic [31:0]  rs_v;
        logic [31:0]  rt_v;
        logic         stall_exp;
        logic         leave;
        logic         allow_exp;
        if (!reset) begin
            leave = 1'b0;
            if (held_q.size() > 0) begin
                c         = decode_word(held_q[0].inst);
                stall_exp = resolve_operand(c.rs, c.use_rs, shadow[c.rs], stage_dests, rs_v);
                stall_exp = resolve_operand(c.rt, c.use_rt, shadow[c.rt], stage_dests, rt_v)
                            || stall_exp;
                check_flag("ds_to_es_valid", !stall_exp, ds_to_es_valid);
                if (!stall_exp) begin
                    check_exec("ds_to_es_bus", pack_exec(c, rs_v, rt_v, held_q[0].pc),
                               ds_to_es_bus);
                    if (c.br_kind != br_none) begin
                        check_branch("br_bus", branch_outcome(c, held_q[0].pc, rs_v, rt_v),
                                     br_bus);
                    end else begin
                        check_flag("br_bus.taken", 1'b0, br_bus.taken);
                    end
                    leave = es_allowin;
                end
            end else begin
                check_flag("ds_to_es_valid", 1'b0, ds_to_es_valid);
                check_flag("br_bus.taken", 1'b0, br_bus.taken);
            end
            allow_exp = held_q.size() == 0 || leave;
            check_flag("ds_allowin", allow_exp, ds_allowin);
            if (leave) begin
                void'(held_q.pop_front());
                received++;
            end
            if (fs_to_ds_valid && allow_exp) begin
                held_q.push_back(fs_to_ds_bus);
                sent++;
            end
            if (ws_to_rf_bus.we && ws_to_rf_bus.addr != '0) begin
                shadow[ws_to_rf_bus.addr] = ws_to_rf_bus.data;
            end
        end
    end

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        ws_to_rf_bus = '{we: 1'b1, addr: addr, data: data};
        tick(1);
        ws_to_rf_bus.we = 1'b0;
    endtask

    task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc);
        int   waited;
        logic accepted;
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus   = '{inst: inst, pc: pc};
        accepted       = 1'b0;
        waited         = 0;
        while (!accepted && waited < MAX_WAIT) begin
            @(negedge clk);
            accepted = ds_allowin;
            tick(1);
            waited++;
        end
        fs_to_ds_valid = 1'b0;
        if (!accepted) begin
            err_timeout++;
            $display("%s: decode never accepted the instruction from fetch", test_name);
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (held_q.size() != 0 && waited < MAX_WAIT) begin
            tick(1);
            waited++;
        end
        if (held_q.size() != 0) begin
            err_timeout++;
            $display("%s: decode never passed its instruction to execute", test_name);
        end
    endtask

    function automatic logic [31:0] edge_value(input int k);
        case (k)
            0: edge_value = 32'h0000_0000;
            1: edge_value = 32'h0000_0001;
            2: edge_value = 32'hffff_ffff;
            3: edge_value = 32'h8000_0000;
            4: edge_value = 32'h7fff_ffff;
            default: edge_value = $random(seed);
        endcase
    endfunction

    // ALU, lw and sw words with valid reserved fields
    function automatic logic [31:0] rand_inst();
        logic [31:0] r;
        logic [5:0]  sh_fn;
        r     = $random(seed);
        sh_fn = 6'({$random(seed)} % 3);
        if (sh_fn != 6'd0) begin
            sh_fn = sh_fn + 6'd1;
        end
        case ({$random(seed)} % 6)
            0: rand_inst = {6'h00, r[25:11], 5'd0, r_funcs[{$random(seed)} % 13]};
            1: rand_inst = {6'h00, 5'd0, r[20:6], sh_fn};
            2: rand_inst = {6'(8 + {$random(seed)} % 7), r[25:0]};
            3: rand_inst = {6'h0f, 5'd0, r[20:0]};
            4: rand_inst = {6'h23, r[25:0]};
            default: rand_inst = {6'h2b, r[25:0]};
        endcase
    endfunction

    initial begin : main
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] va;
        logic [31:0] word;
        logic [31:0] inst;
        seed           = 32'h3763;
        r_funcs        = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b, 6'h24,
                           6'h25, 6'h26, 6'h27, 6'h04, 6'h06, 6'h07};
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b1;
        ws_to_rf_bus   = '0;
        stage_dests    = '0;
        bp_done        = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        tick(5);
        reset = 1'b0;

        test_name = "reset_and_regs";
        tick(1);
        for (int i = 1; i < NUM_REGS; i++) begin
            write_reg(5'(i), $random(seed));
        end
        write_reg(5'd0, $random(seed));
        send_inst({6'h00, 5'd0, 5'd0, 5'd3, 5'd0, 6'h21}, 32'h0040_0000);   // addu $3,$0,$0
        wait_drained();

        test_name = "alu_mem_decode";
        for (int i = 0; i < 40; i++) begin
            send_inst(rand_inst(), 32'h0040_1000 + 32'(4 * i));
        end
        wait_drained();

        test_name = "forwarding";
        for (int s = 0; s < NUM_FWD_STAGES; s++) begin
            stage_dests[s] = '{we: 1'b1, dest: 5'd9, fwd_valid: 1'b1, fwd_data: $random(seed)};
        end
        for (int s = 0; s < NUM_FWD_STAGES; s++) begin
            send_inst({6'h00, 5'd9, 5'd9, 5'd4, 5'd0, 6'h21}, 32'h0040_2000);
            wait_drained();
            stage_dests[s].we = 1'b0;   // next farther stage takes over
        end

        test_name = "stall";
        stage_dests[1] = '{we: 1'b1, dest: 5'd9, fwd_valid: 1'b0, fwd_data: $random(seed)};
        send_inst({6'h00, 5'd2, 5'd9, 5'd5, 5'd0, 6'h23}, 32'h0040_3000);
        tick(4);
        stage_dests[1].fwd_valid = 1'b1;
        wait_drained();
        stage_dests = '0;

        test_name = "branches";
        for (int i = 0; i < 36; i++) begin
            ra   = 5'(1 + {$random(seed)} % 31);
            rb   = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
            va   = edge_value({$random(seed)} % 6);
            word = $random(seed);
            write_reg(ra, va);
            write_reg(rb, word[31] ? va : edge_value({$random(seed)} % 6));
            case (i % 9)
                0: inst = {6'h04, ra, rb, word[15:0]};
                1: inst = {6'h05, ra, rb, word[15:0]};
                2: inst = {6'h01, ra, 5'd1, word[15:0]};
                3: inst = {6'h01, ra, 5'd0, word[15:0]};
                4: inst = {6'h06, ra, 5'd0, word[15:0]};
                5: inst = {6'h07, ra, 5'd0, word[15:0]};
                6: inst = {6'h02, word[25:0]};
                7: inst = {6'h03, word[25:0]};
                default: inst = {6'h00, ra, 15'd0, 6'h08};
            endcase
            send_inst(inst, $random(seed) & ~32'h3);
            wait_drained();
        end

        test_name = "back_pressure";
        for (int i = 0; i < BP_COUNT; i++) begin
            bp_insts[i] = rand_inst();
        end
        fork
            begin
                for (int i = 0; i < BP_COUNT; i++) begin
                    send_inst(bp_insts[i], 32'h0040_4000 + 32'(4 * i));
                end
                bp_done = 1'b1;
            end
            begin
                while (!bp_done) begin
                    es_allowin = $random(seed);
                    tick(1 + {$random(seed)} % 4);
                end
                es_allowin = 1'b1;
            end
        join
        wait_drained();

        tick(2);
        $write("exec errors %0d, branch errors %0d, flag errors %0d, ",
               err_exec, err_branch, err_flag);
        $display("timeouts %0d, sent %0d, received %0d", err_timeout, sent, received);
        if (err_exec + err_branch + err_flag + err_timeout == 0 && sent == received) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+tests
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/hazard_unit.sv
rtl/branch_unit.sv
rtl/id_stage.sv
tests/id_stage_tb.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - files:
      - rtl/id_pkg.sv
      - rtl/inst_decoder.sv
      - rtl/regfile.sv
      - rtl/hazard_unit.sv
      - rtl/branch_unit.sv
      - rtl/id_stage.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/id_stage_tb.sv
